//--- Bender.yml
package:
  name: conv_layer

sources:
  - conv_pkg.sv
  - conv_mem.sv
  - conv_window_decode.sv
  - conv_mac_array.sv
  - conv_result.sv
  - conv_layer_top.sv
  - target: test
    files:
      - tb_conv_layer.sv

//--- conv_layer_top.sv
//////////////////////////////////////////////////////////////////////
// conv layer engine top, image and weight memories feeding
// decode, execute and result stages
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module conv_layer_top (
	input  logic                clk,
	input  logic                rst,
	// image load, only while en is low
	input  logic                img_wr,
	input  conv_pkg::img_addr_t img_waddr,
	input  conv_pkg::pix_t      img_wdata,
	// weight load, one vector per tap
	input  logic                wgt_wr,
	input  conv_pkg::tap_t      wgt_waddr,
	input  conv_pkg::wvec_t     wgt_wdata,
	// bias load
	input  logic                bias_wr,
	input  logic [1:0]          bias_sel,
	input  conv_pkg::pix_t      bias_wdata,
	// control
	input  logic                en,
	output logic                done,
	// output pixel handshake
	output logic                out_req,
	output conv_pkg::out_addr_t out_addr,
	output conv_pkg::ofm_t      ofm,
	input  logic                out_ack
);
	import conv_pkg::*;

	img_addr_t img_raddr;
	tap_t      wgt_raddr;
	pix_t      pix;        // image read data
	wvec_t     wgt;        // weight read data
	logic      tap_first;
	logic      tap_last;
	out_addr_t win_addr;
	acc_vec_t  acc;
	logic      acc_valid;
	out_addr_t acc_addr;
	logic      hold_busy;

	//////////////////////////////////////////////////////////////////////
	// memories
	//////////////////////////////////////////////////////////////////////
	conv_mem #(.word_t(pix_t), .DEPTH(IMG_DEPTH)) i_img_mem (
		.clk   (clk),
		.wr    (img_wr),
		.waddr (img_waddr),
		.wdata (img_wdata),
		.raddr (img_raddr),
		.rdata (pix)
	);

	conv_mem #(.word_t(wvec_t), .DEPTH(N_TAPS)) i_wgt_mem (
		.clk   (clk),
		.wr    (wgt_wr),
		.waddr (wgt_waddr),
		.wdata (wgt_wdata),
		.raddr (wgt_raddr),
		.rdata (wgt)
	);

	//////////////////////////////////////////////////////////////////////
	// pipeline
	//////////////////////////////////////////////////////////////////////
	conv_window_decode i_decode (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.hold_busy (hold_busy),
		.img_raddr (img_raddr),
		.wgt_raddr (wgt_raddr),
		.tap_first (tap_first),
		.tap_last  (tap_last),
		.win_addr  (win_addr),
		.done      (done)
	);

	conv_mac_array i_mac (
		.clk       (clk),
		.rst       (rst),
		.pix       (pix),
		.wgt       (wgt),
		.tap_first (tap_first),
		.tap_last  (tap_last),
		.win_addr  (win_addr),
		.acc       (acc),
		.acc_valid (acc_valid),
		.acc_addr  (acc_addr)
	);

	conv_result i_result (
		.clk        (clk),
		.rst        (rst),
		.bias_wr    (bias_wr),
		.bias_sel   (bias_sel),
		.bias_wdata (bias_wdata),
		.acc        (acc),
		.acc_valid  (acc_valid),
		.acc_addr   (acc_addr),
		.out_ack    (out_ack),
		.hold_busy  (hold_busy),
		.out_req    (out_req),
		.out_addr   (out_addr),
		.ofm        (ofm)
	);

endmodule

//--- conv_mac_array.sv
//////////////////////////////////////////////////////////////////////
// execute stage, one signed multiply-accumulate per output channel
// a window's first tap restarts the sum, its last tap flags it valid
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module conv_mac_array (
	input  logic                clk,
	input  logic                rst,
	input  conv_pkg::pix_t      pix,       // image sample for this tap
	input  conv_pkg::wvec_t     wgt,       // weights of every lane for this tap
	input  logic                tap_first,
	input  logic                tap_last,
	input  conv_pkg::out_addr_t win_addr,
	output conv_pkg::acc_vec_t  acc,
	output logic                acc_valid, // one cycle after the last tap
	output conv_pkg::out_addr_t acc_addr
);
	import conv_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// mac lanes
	//////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < CH_OUT; i++) begin : g_lane
		acc_t prod;

		// Q2.14 x Q2.14 gives Q4.28, fits the accumulator
		assign prod = acc_t'(pix) * acc_t'($signed(wgt[i]));

		always_ff @(posedge clk) begin
			if (tap_first)
				acc[i] <= prod;          // new window
			else
				acc[i] <= acc[i] + prod; // bubbles read zero and add nothing
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			acc_valid <= 1'b0;
		else
			acc_valid <= tap_last;
	end

	always_ff @(posedge clk) begin
		if (tap_last)
			acc_addr <= win_addr; // stays with acc_valid
	end

	// a window always spans more than one tap
	a_flags_apart: assert property (@(posedge clk) disable iff (!rst)
		!(tap_first && tap_last));

endmodule

//--- conv_mem.sv
//////////////////////////////////////////////////////////////////////
// register-array memory, one write port and a registered read port
// holds either image samples or weight vectors via the word type
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module conv_mem #(
	parameter type word_t = logic [15:0],
	parameter int  DEPTH  = 16
) (
	input  logic                     clk,
	input  logic                     wr,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  word_t                    wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output word_t                    rdata
);

	word_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr)
			mem[waddr] <= wdata; // loads only happen with the engine idle
	end

	// read data one cycle after the address
	// addresses past the last word read as zero, the decoder parks
	// there when idle so bubbles feed zero products into the macs
	always_ff @(posedge clk) begin
		if (raddr < DEPTH)
			rdata <= mem[raddr];
		else
			rdata <= '0;
	end

	// a live read never collides with a load of the same word
	a_no_rw_collide: assert property (@(posedge clk)
		(wr && (raddr < DEPTH)) |-> (waddr != raddr));

endmodule

//--- conv_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared geometry, fixed-point types and requantisation constants
// for the stride-2 conv layer engine and its testbench
//////////////////////////////////////////////////////////////////////
package conv_pkg;

	//////////////////////////////////////////////////////////////////////
	// layer geometry
	//////////////////////////////////////////////////////////////////////
	localparam int W_IN   = 10;        // padded input width and height
	localparam int CH_IN  = 2;         // input channels
	localparam int K_DIM  = 3;         // kernel is K_DIM x K_DIM
	localparam int STRIDE = 2;
	localparam int W_OUT  = (W_IN - K_DIM) / STRIDE + 1; // 4
	localparam int CH_OUT = 4;         // one mac lane per output channel

	localparam int KK        = K_DIM * K_DIM;   // taps per input channel
	localparam int PLANE     = W_IN * W_IN;     // words per image channel
	localparam int N_TAPS    = CH_IN * KK;      // 18 taps per window
	localparam int IMG_DEPTH = CH_IN * PLANE;   // 200 image words
	localparam int N_OUT     = W_OUT * W_OUT;   // 16 output pixels

	// counter widths for the window walk
	localparam int K_W   = $clog2(K_DIM);
	localparam int CH_W  = $clog2(CH_IN);
	localparam int POS_W = $clog2(W_OUT);

	//////////////////////////////////////////////////////////////////////
	// fixed point, Q2.14 samples into a 32 bit accumulator
	//////////////////////////////////////////////////////////////////////
	localparam int DATA_W    = 16;
	localparam int ACC_W     = 32;
	localparam int FRAC_BITS = 14;

	typedef logic [$clog2(IMG_DEPTH)-1:0] img_addr_t; // 8 bits
	typedef logic [$clog2(N_TAPS)-1:0]    tap_t;      // 5 bits, also weight address
	typedef logic [$clog2(N_OUT)-1:0]     out_addr_t; // 4 bits, row * W_OUT + col

	typedef logic signed [DATA_W-1:0] pix_t;     // image word and bias value
	typedef pix_t [CH_OUT-1:0]        wvec_t;    // one weight per output channel
	typedef logic signed [ACC_W-1:0]  acc_t;
	typedef acc_t [CH_OUT-1:0]        acc_vec_t;
	typedef logic [CH_OUT-1:0][DATA_W-1:0] ofm_t; // rectified results

	localparam tap_t LAST_TAP = tap_t'(N_TAPS - 1);

	// requantisation: result is bits RQ_MSB..FRAC_BITS of the biased sum,
	// negative sums rectify to 0, sums at or above SAT_LIM clip to SAT_MAX
	localparam int                RQ_MSB  = FRAC_BITS + DATA_W - 1;  // 29
	localparam acc_t              SAT_LIM = acc_t'(1) <<< RQ_MSB;    // 2^29
	localparam logic [DATA_W-1:0] SAT_MAX = {1'b0, {(DATA_W-1){1'b1}}}; // 32767

endpackage

//--- conv_result.sv
//////////////////////////////////////////////////////////////////////
// result stage, bias add, rectify and saturate into a holding register
// each output pixel leaves on a four-phase out_req/out_ack handshake
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module conv_result (
	input  logic                clk,
	input  logic                rst,
	input  logic                bias_wr,
	input  logic [1:0]          bias_sel,   // output channel of the bias
	input  conv_pkg::pix_t      bias_wdata,
	input  conv_pkg::acc_vec_t  acc,
	input  logic                acc_valid,
	input  conv_pkg::out_addr_t acc_addr,
	input  logic                out_ack,
	output logic                hold_busy,  // capture until ack seen high
	output logic                out_req,
	output conv_pkg::out_addr_t out_addr,
	output conv_pkg::ofm_t      ofm
);
	import conv_pkg::*;

	typedef enum logic [1:0] {
		HS_IDLE, // waiting for a captured pixel
		HS_REQ,  // out_req high, waiting for ack
		HS_DROP  // out_req low, waiting for ack to fall
	} hs_state_t;

	hs_state_t hs_state;
	pix_t      bias_q [CH_OUT];
	acc_t      sum    [CH_OUT];
	ofm_t      rq;

	always_ff @(posedge clk) begin
		if (bias_wr)
			bias_q[bias_sel] <= bias_wdata;
	end

	//////////////////////////////////////////////////////////////////////
	// requantise, bias aligned to the Q4.28 accumulator
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < CH_OUT; i++) begin
			sum[i] = acc[i] + (acc_t'(bias_q[i]) <<< FRAC_BITS);
			if (sum[i] < 0)
				rq[i] = '0;                        // rectify
			else if (sum[i] >= SAT_LIM)
				rq[i] = SAT_MAX;                   // clip
			else
				rq[i] = sum[i][RQ_MSB:FRAC_BITS];  // back to Q2.14
		end
	end

	// holding register, decode stalls so a capture never lands on a full one
	always_ff @(posedge clk) begin
		if (acc_valid) begin
			ofm      <= rq;
			out_addr <= acc_addr;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// four-phase handshake
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			hs_state  <= HS_IDLE;
			out_req   <= 1'b0;
			hold_busy <= 1'b0;
		end else begin
			case (hs_state)
				HS_IDLE: if (hold_busy) begin // ack already seen low
					out_req  <= 1'b1;
					hs_state <= HS_REQ;
				end
				HS_REQ: if (out_ack) begin
					out_req   <= 1'b0;
					hold_busy <= 1'b0; // register free again
					hs_state  <= HS_DROP;
				end
				HS_DROP: if (!out_ack)
					hs_state <= HS_IDLE;
				default: hs_state <= HS_IDLE;
			endcase
			if (acc_valid)
				hold_busy <= 1'b1;
		end
	end

	a_req_until_ack: assert property (@(posedge clk) disable iff (!rst)
		(out_req && !out_ack) |=> out_req);

	a_data_stable: assert property (@(posedge clk) disable iff (!rst)
		(out_req && !out_ack) |=> ($stable(out_addr) && $stable(ofm)));

endmodule

//--- conv_window_decode.sv
//////////////////////////////////////////////////////////////////////
// decode stage that walks output pixels and their 18 kernel taps
// issues image and weight read addresses and stalls on a full result
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module conv_window_decode (
	input  logic                clk,
	input  logic                rst,
	input  logic                en,        // level signal, runs the engine while high
	input  logic                hold_busy, // result holding register occupied
	output conv_pkg::img_addr_t img_raddr,
	output conv_pkg::tap_t      wgt_raddr,
	output logic                tap_first, // aligned with memory read data
	output logic                tap_last,
	output conv_pkg::out_addr_t win_addr,
	output logic                done
);
	import conv_pkg::*;

	tap_t              tap_q;      // tap index inside the window
	logic [K_W-1:0]    kc_q;       // kernel column
	logic [K_W-1:0]    kr_q;       // kernel row
	logic [CH_W-1:0]   kch_q;      // input channel
	logic [POS_W-1:0]  col_q;      // output pixel column
	logic [POS_W-1:0]  row_q;      // output pixel row
	logic              all_issued; // last tap of last window has gone out
	logic              last_cap;   // last window sits in the result stage
	logic              active;
	logic              stall;
	logic              issue;
	img_addr_t         origin;
	img_addr_t         offset;

	assign active = en && !all_issued;
	assign stall  = hold_busy && (tap_q == LAST_TAP); // only the closing tap waits
	assign issue  = active && !stall;

	// window origin is the output position scaled by the stride
	assign origin = img_addr_t'((row_q * STRIDE) * W_IN + col_q * STRIDE);
	assign offset = img_addr_t'(kch_q * PLANE + kr_q * W_IN + kc_q); // channel-major planes

	// park both addresses out of range when nothing is issued
	assign img_raddr = issue ? img_addr_t'(origin + offset) : '1;
	assign wgt_raddr = issue ? tap_q : '1;

	//////////////////////////////////////////////////////////////////////
	// tap and pixel counters
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap_q      <= '0;
			kc_q       <= '0;
			kr_q       <= '0;
			kch_q      <= '0;
			col_q      <= '0;
			row_q      <= '0;
			all_issued <= 1'b0;
			last_cap   <= 1'b0;
			done       <= 1'b0;
			tap_first  <= 1'b0;
			tap_last   <= 1'b0;
		end else if (!en) begin // idle so rewind for the next run
			tap_q      <= '0;
			kc_q       <= '0;
			kr_q       <= '0;
			kch_q      <= '0;
			col_q      <= '0;
			row_q      <= '0;
			all_issued <= 1'b0;
			last_cap   <= 1'b0;
			done       <= 1'b0;
			tap_first  <= 1'b0;
			tap_last   <= 1'b0;
		end else begin
			tap_first <= issue && (tap_q == '0);
			tap_last  <= issue && (tap_q == LAST_TAP);
			if (issue) begin
				if (tap_q == LAST_TAP) begin // window complete so move to the next pixel
					tap_q <= '0;
					kc_q  <= '0;
					kr_q  <= '0;
					kch_q <= '0;
					if (col_q == POS_W'(W_OUT - 1)) begin
						col_q <= '0;
						if (row_q == POS_W'(W_OUT - 1)) begin
							row_q      <= '0;
							all_issued <= 1'b1;
						end else
							row_q <= row_q + 1'b1;
					end else
						col_q <= col_q + 1'b1;
				end else begin
					tap_q <= tap_q + 1'b1;
					if (kc_q == K_W'(K_DIM - 1)) begin
						kc_q <= '0;
						if (kr_q == K_W'(K_DIM - 1)) begin
							kr_q  <= '0;
							kch_q <= kch_q + 1'b1; // next input plane
						end else
							kr_q <= kr_q + 1'b1;
					end else
						kc_q <= kc_q + 1'b1;
				end
			end
			// hold_busy rises on the last capture and falls on its ack
			if (all_issued && hold_busy)
				last_cap <= 1'b1;
			if (last_cap && !hold_busy)
				done <= 1'b1; // held until en drops
		end
	end

	// pixel index travels with the tap flags
	always_ff @(posedge clk) begin
		win_addr <= out_addr_t'({row_q, col_q});
	end

	a_addr_range: assert property (@(posedge clk) disable iff (!rst)
		issue |-> (img_raddr < IMG_DEPTH));

	// while running the tap counter holds still only on the closing tap
	a_stall_tap: assert property (@(posedge clk) disable iff (!rst)
		active |=> ((tap_q != $past(tap_q)) || (tap_q == LAST_TAP)));

endmodule

//--- flist.f
conv_pkg.sv
conv_mem.sv
conv_window_decode.sv
conv_mac_array.sv
conv_result.sv
conv_layer_top.sv
tb_conv_layer.sv

//--- tb_conv_layer.sv
//////////////////////////////////////////////////////////////////////
// self-checking testbench for the conv layer engine that loads each
// test row, models the layer and checks every handshaked output pixel
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_conv_layer;
	import conv_pkg::*;

	typedef enum int {M_RAND, M_NEG, M_BIG, M_ZERO} mode_t;
	typedef struct {
		string name;
		mode_t img_mode;
		mode_t wgt_mode;
		mode_t bias_mode;
		int    ack_min;   // ack delay range in cycles
		int    ack_max;
	} row_t;

	localparam int N_ROWS = 4;

	logic clk, rst, en, done, out_req, out_ack;
	logic img_wr, wgt_wr, bias_wr;
	img_addr_t img_waddr;
	tap_t wgt_waddr;
	pix_t img_wdata, bias_wdata;
	wvec_t wgt_wdata;
	logic [1:0] bias_sel;
	out_addr_t out_addr;
	ofm_t ofm;

	row_t tests [N_ROWS];
	int seed = 83811;
	int img_val [IMG_DEPTH];
	int wgt_val [N_TAPS][CH_OUT];
	int bias_val [CH_OUT];
	int exp_ofm [N_OUT][CH_OUT]; // model results per pixel and channel
	int n_seen;                  // handshakes taken in this run
	int cur;                     // current table row

	conv_layer_top i_dut (
		.clk(clk), .rst(rst),
		.img_wr(img_wr), .img_waddr(img_waddr), .img_wdata(img_wdata),
		.wgt_wr(wgt_wr), .wgt_waddr(wgt_waddr), .wgt_wdata(wgt_wdata),
		.bias_wr(bias_wr), .bias_sel(bias_sel), .bias_wdata(bias_wdata),
		.en(en), .done(done),
		.out_req(out_req), .out_addr(out_addr), .ofm(ofm), .out_ack(out_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_value(string what, logic [63:0] exp, logic [63:0] act);
		if (exp !== act)
			abort_run($sformatf("Mismatch %s %s: expected %0h, actual %0h",
				tests[cur].name, what, exp, act));
	endtask

	function automatic int gen_value(mode_t m);
		int t;
		t = {$random(seed)} % 4096;
		case (m)
			M_RAND:  return t - 2048;       // about +-0.125
			M_NEG:   return -1 - t;         // strictly negative
			M_BIG:   return 8192 + t % 2048; // 0.5 and up so 18 taps still fit 32 bits
			default: return 0;
		endcase
	endfunction

	// rectify and clip at 2^29 or keep bits 29..14
	function automatic int requant(int s);
		if (s < 0)
			return 0;
		if (s >= (1 << 29))
			return 32767;
		return (s >>> 14) & 16'hffff;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus generation, loading and reference model
	//////////////////////////////////////////////////////////////////////
	task automatic load_row();
		logic [63:0] vec;
		for (int a = 0; a < IMG_DEPTH; a++) begin
			img_val[a] = gen_value(tests[cur].img_mode);
			@(posedge clk);
			img_wr <= 1'b1;
			img_waddr <= img_addr_t'(a);
			img_wdata <= pix_t'(img_val[a]);
		end
		for (int t = 0; t < N_TAPS; t++) begin
			for (int o = 0; o < CH_OUT; o++) begin
				wgt_val[t][o] = gen_value(tests[cur].wgt_mode);
				vec[o*16 +: 16] = wgt_val[t][o][15:0]; // lane o in bits o*16
			end
			@(posedge clk);
			img_wr <= 1'b0;
			wgt_wr <= 1'b1;
			wgt_waddr <= tap_t'(t);
			wgt_wdata <= vec;
		end
		for (int o = 0; o < CH_OUT; o++) begin
			bias_val[o] = gen_value(tests[cur].bias_mode);
			@(posedge clk);
			wgt_wr <= 1'b0;
			bias_wr <= 1'b1;
			bias_sel <= 2'(o);
			bias_wdata <= pix_t'(bias_val[o]);
		end
		@(posedge clk);
		bias_wr <= 1'b0;
	endtask

	task automatic compute_expected();
		int s;
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				for (int o = 0; o < CH_OUT; o++) begin
					s = bias_val[o] * 16384; // bias lined up with Q4.28
					for (int ch = 0; ch < 2; ch++)
						for (int kr = 0; kr < 3; kr++)
							for (int kc = 0; kc < 3; kc++)
								s += img_val[ch*100 + (2*r + kr)*10 + 2*c + kc] *
									wgt_val[ch*9 + kr*3 + kc][o];
					exp_ofm[r*4 + c][o] = requant(s);
				end
	endtask

	//////////////////////////////////////////////////////////////////////
	// ack responder that checks order and data of each pixel
	//////////////////////////////////////////////////////////////////////
	initial begin
		int d;
		forever begin
			@(posedge clk);
			if (out_req && !out_ack) begin
				check_value("done early", 0, done);
				check_value("out_addr", n_seen, out_addr);
				for (int o = 0; o < CH_OUT; o++)
					check_value($sformatf("px%0d ch%0d", n_seen, o),
						exp_ofm[n_seen % N_OUT][o], ofm[o]);
				n_seen++;
				d = tests[cur].ack_min +
					{$random(seed)} % (tests[cur].ack_max - tests[cur].ack_min + 1);
				for (int k = 0; k < d; k++) begin
					@(posedge clk);
					check_value("req dropped before ack", 1, out_req);
				end
				out_ack <= 1'b1;
				do @(posedge clk); while (out_req); // phase 3 where req falls
				out_ack <= 1'b0;
				@(posedge clk); // req may only rise once ack low is seen
				check_value("req rose before ack fell", 0, out_req);
			end
		end
	end

	// watchdog sized from the table once it is filled in
	initial begin
		int ack_top;
		@(posedge rst);
		ack_top = 0;
		foreach (tests[i])
			if (tests[i].ack_max > ack_top)
				ack_top = tests[i].ack_max;
		repeat (N_ROWS * N_OUT * (N_TAPS + 3 + ack_top) * 4) @(posedge clk);
		abort_run("timeout: engine stopped producing outputs");
	end

	initial begin
		tests[0] = '{"random_fast", M_RAND, M_RAND, M_RAND, 0, 0};
		tests[1] = '{"negative_weights", M_BIG, M_NEG, M_ZERO, 0, 3};
		tests[2] = '{"saturate", M_BIG, M_BIG, M_BIG, 1, 5};
		tests[3] = '{"random_slow_ack", M_RAND, M_RAND, M_RAND, 0, 30}; // forces stalls
		cur = 0;
		n_seen = 0;
		rst = 1'b0;
		en = 1'b0;
		out_ack = 1'b0;
		img_wr = 1'b0;
		img_waddr = '0;
		img_wdata = '0;
		wgt_wr = 1'b0;
		wgt_waddr = '0;
		wgt_wdata = '0;
		bias_wr = 1'b0;
		bias_sel = '0;
		bias_wdata = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		check_value("out_req after reset", 0, out_req);
		check_value("done after reset", 0, done);
		for (cur = 0; cur < N_ROWS; cur++) begin
			load_row();
			compute_expected();
			n_seen = 0;
			@(posedge clk);
			en <= 1'b1;
			do @(posedge clk); while (!done);
			check_value("handshakes at done", N_OUT, n_seen);
			check_value("out_req at done", 0, out_req);
			repeat (6) begin // done holds and nothing more comes out
				@(posedge clk);
				check_value("done held", 1, done);
				check_value("extra out_req", 0, out_req);
			end
			en <= 1'b0;
			repeat (3) @(posedge clk);
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule
